// ==== ulaVideoPkg.sv ====
package ulaVideoPkg;

   // Raster position and video RAM address types
   typedef logic [8:0]  hCount_t;
   typedef logic [8:0]  vCount_t;
   typedef logic [13:0] vramAddr_t;

   // Bright bit on top of GRB
   typedef logic [3:0] igrb_t;

   // Three bits each of G, R and B, G in the top bits
   typedef logic [8:0] rgb9_t;

   // Spectrum attribute byte
   typedef struct packed {
      logic       flash;
      logic       bright;
      logic [2:0] paper;
      logic [2:0] ink;
   } attr_t;

   ////////////////////////////////////////////////////////////
   // Sinclair 48K raster
   ////////////////////////////////////////////////////////////

   localparam int LineLength  = 448;
   localparam int FrameLines  = 312;
   localparam int PaperLastX  = 255;
   localparam int PaperLastY  = 191;
   localparam int FetchLead   = 8;
   localparam int IntLine     = 248;
   localparam int IntFirst    = 2;
   localparam int IntLast     = 65;
   localparam int HsyncFirst  = 344;
   localparam int HsyncLast   = 375;
   localparam int VsyncFirst  = 248;
   localparam int VsyncLast   = 251;

   // Phases of hc[2:0] inside each character cell
   localparam int ColumnLatchPhase = 3;
   localparam int AttrOutPhase     = 4;

   ////////////////////////////////////////////////////////////
   // IGRB to GGGRRRBBB
   ////////////////////////////////////////////////////////////

   localparam logic [2:0] LevelNone = 3'b000;
   localparam logic [2:0] LevelHalf = 3'b101;
   localparam logic [2:0] LevelFull = 3'b111;

   // Index 0 and 8 are both black
   localparam rgb9_t ColourTable [16] = '{
      {LevelNone, LevelNone, LevelNone},
      {LevelNone, LevelNone, LevelHalf},
      {LevelNone, LevelHalf, LevelNone},
      {LevelNone, LevelHalf, LevelHalf},
      {LevelHalf, LevelNone, LevelNone},
      {LevelHalf, LevelNone, LevelHalf},
      {LevelHalf, LevelHalf, LevelNone},
      {LevelHalf, LevelHalf, LevelHalf},
      {LevelNone, LevelNone, LevelNone},
      {LevelNone, LevelNone, LevelFull},
      {LevelNone, LevelFull, LevelNone},
      {LevelNone, LevelFull, LevelFull},
      {LevelFull, LevelNone, LevelNone},
      {LevelFull, LevelNone, LevelFull},
      {LevelFull, LevelFull, LevelNone},
      {LevelFull, LevelFull, LevelFull}
   };

endpackage

// ==== ulaCpuPkg.sv ====
package ulaCpuPkg;

   // Z80 bus words
   typedef logic [15:0] cpuAddr_t;
   typedef logic [7:0]  cpuData_t;

   ////////////////////////////////////////////////////////////
   // Port 0xFE
   ////////////////////////////////////////////////////////////

   // Any even address selects the ULA
   localparam int FeSelectBit = 0;

   // Write data layout
   localparam int FeBorderLsb  = 0;
   localparam int FeBorderBits = 3;
   localparam int FeMicBit     = 3;
   localparam int FeSpkBit     = 4;

endpackage

// ==== ulaFetchIf.sv ====
`timescale 1ns/1ps

interface ulaFetchIf;

   // Video RAM address select, one cycle each
   logic bitmapAddr;
   logic attrAddr;

   // Capture strobes for the fetch registers
   logic bitmapLoad;
   logic attrLoad;

   // Serializer and attribute output stage loads
   logic shiftLoad;
   logic attrOutLoad;

   // High while the shifted paper area is on screen
   logic paperEnable;

   modport control (
      output bitmapAddr, attrAddr, bitmapLoad, attrLoad,
      output shiftLoad, attrOutLoad, paperEnable
   );

   modport datapath (
      input bitmapAddr, attrAddr, bitmapLoad, attrLoad,
      input shiftLoad, attrOutLoad, paperEnable
   );

endinterface

// ==== rasterCounter.sv ====
`timescale 1ns/1ps

module rasterCounter
   import ulaVideoPkg::*;
#(
   parameter int FlashBits = 5
) (
   input  logic    clk7,
   input  logic    rst_n,
   output hCount_t hc,
   output vCount_t vc,
   output logic    hsync,
   output logic    vsync,
   output logic    intN,
   output logic    flashPhase
);

   localparam hCount_t HcLast     = hCount_t'(LineLength - 1);
   localparam vCount_t VcLast     = vCount_t'(FrameLines - 1);
   localparam hCount_t HsFirst    = hCount_t'(HsyncFirst);
   localparam hCount_t HsLast     = hCount_t'(HsyncLast);
   localparam vCount_t VsFirst    = vCount_t'(VsyncFirst);
   localparam vCount_t VsLast     = vCount_t'(VsyncLast);
   localparam vCount_t IntVc      = vCount_t'(IntLine);
   localparam hCount_t IntFirstHc = hCount_t'(IntFirst);
   localparam hCount_t IntLastHc  = hCount_t'(IntLast);

   logic                 lineEnd;
   logic [FlashBits-1:0] flashCount;

   assign lineEnd = (hc == HcLast);

   // Pixel and line counters
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         hc <= '0;
         vc <= '0;
      end else begin
         hc <= lineEnd ? '0 : hc + 1'b1;
         if (lineEnd) begin
            // Frame wraps after the last line
            vc <= (vc == VcLast) ? '0 : vc + 1'b1;
         end
      end
   end

   // One tick per frame, at the start of the interrupt line
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         flashCount <= '0;
      end else if (vc == IntVc && hc == '0) begin
         flashCount <= flashCount + 1'b1;
      end
   end

   assign flashPhase = flashCount[FlashBits-1];

   // Active low windows straight from the counters
   assign hsync = !(hc >= HsFirst && hc <= HsLast);
   assign vsync = !(vc >= VsFirst && vc <= VsLast);

   // 64 pixel clocks, i.e. 32 T-states
   assign intN = !(vc == IntVc && hc >= IntFirstHc && hc <= IntLastHc);

endmodule

// ==== fetchControl.sv ====
`timescale 1ns/1ps

module fetchControl
   import ulaVideoPkg::*;
(
   input  hCount_t        hc,
   input  vCount_t        vc,
   ulaFetchIf.control     fetch
);

   // Fetches run FetchLead pixels ahead of the shifted display window
   localparam hCount_t FetchLastHc  = hCount_t'(PaperLastX);
   localparam hCount_t PaperFirstHc = hCount_t'(FetchLead);
   localparam hCount_t PaperLastHc  = hCount_t'(PaperLastX + FetchLead);
   localparam vCount_t PaperLastVc  = vCount_t'(PaperLastY);

   logic paperLine;
   logic fetchWindow;
   logic cellPhase;

   assign paperLine   = (vc <= PaperLastVc);
   assign fetchWindow = paperLine && (hc <= FetchLastHc);
   assign cellPhase   = (hc[2:0] == 3'(AttrOutPhase));

   ////////////////////////////////////////////////////////////
   // Video RAM fetch sequence
   ////////////////////////////////////////////////////////////

   // Two cells per 16 clocks, bitmap then attribute
   always_comb begin
      fetch.bitmapAddr = 1'b0;
      fetch.bitmapLoad = 1'b0;
      fetch.attrAddr   = 1'b0;
      fetch.attrLoad   = 1'b0;
      if (fetchWindow) begin
         case (hc[3:0])
            4'd8, 4'd12: begin
               fetch.bitmapAddr = 1'b1;
            end
            4'd9, 4'd13: begin
               // Data valid on the second cycle
               fetch.bitmapAddr = 1'b1;
               fetch.bitmapLoad = 1'b1;
            end
            4'd10, 4'd14: begin
               fetch.attrAddr = 1'b1;
            end
            4'd11, 4'd15: begin
               fetch.attrAddr = 1'b1;
               fetch.attrLoad = 1'b1;
            end
            default: begin
               // First half of each 16 clocks is free
               fetch.bitmapAddr = 1'b0;
            end
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // Display strobes
   ////////////////////////////////////////////////////////////

   assign fetch.paperEnable = paperLine && (hc >= PaperFirstHc) && (hc <= PaperLastHc);

   // Attribute stage runs everywhere so the border follows it
   assign fetch.attrOutLoad = cellPhase;

   // Serializer only fed inside paper
   assign fetch.shiftLoad = fetch.paperEnable && cellPhase;

endmodule

// ==== videoDatapath.sv ====
`timescale 1ns/1ps

module videoDatapath
   import ulaVideoPkg::*;
(
   input  logic                       clk7,
   input  hCount_t                    hc,
   input  vCount_t                    vc,
   input  logic [7:0]                 vramData,
   input  logic [$bits(igrb_t)-2:0]   border,
   input  logic                       flashPhase,
   ulaFetchIf.datapath                fetch,
   output vramAddr_t                  va,
   output rgb9_t                      rgb
);

   logic [4:0] colAddr;
   logic [7:0] bitmapData;
   attr_t      attrData;
   logic [7:0] shifter;
   attr_t      attrIn;
   attr_t      attrOut;
   logic       pixelBit;
   igrb_t      colourIndex;

   ////////////////////////////////////////////////////////////
   // Video RAM addressing
   ////////////////////////////////////////////////////////////

   // Column held for the whole fetch pair
   always_ff @(posedge clk7) begin
      if (hc[2:0] == 3'(ColumnLatchPhase)) begin
         colAddr <= hc[7:3];
      end
   end

   // Bitmap lines interleaved by thirds, attributes in a flat block at 0x1800
   always_comb begin
      va = '0;
      if (fetch.bitmapAddr) begin
         va = {1'b0, vc[7:6], vc[2:0], vc[5:3], colAddr};
      end else if (fetch.attrAddr) begin
         va = {1'b0, 3'b110, vc[7:3], colAddr};
      end
   end

   ////////////////////////////////////////////////////////////
   // Fetch registers and serializer
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk7) begin
      if (fetch.bitmapLoad) begin
         bitmapData <= vramData;
      end
      if (fetch.attrLoad) begin
         attrData <= attr_t'(vramData);
      end
   end

   // MSB first, empties to paper colour between loads
   always_ff @(posedge clk7) begin
      if (fetch.shiftLoad) begin
         shifter <= bitmapData;
      end else begin
         shifter <= {shifter[6:0], 1'b0};
      end
   end

   ////////////////////////////////////////////////////////////
   // Attribute stage
   ////////////////////////////////////////////////////////////

   // Border shows up as paper, no bright, no flash
   always_comb begin
      if (fetch.paperEnable) begin
         attrIn = attrData;
      end else begin
         attrIn.flash  = 1'b0;
         attrIn.bright = 1'b0;
         attrIn.paper  = border;
         attrIn.ink    = 3'b000;
      end
   end

   always_ff @(posedge clk7) begin
      if (fetch.attrOutLoad) begin
         attrOut <= attrIn;
      end
   end

   ////////////////////////////////////////////////////////////
   // Colour output
   ////////////////////////////////////////////////////////////

   // Flash swaps ink and paper
   assign pixelBit = shifter[7] ^ (attrOut.flash & flashPhase);

   assign colourIndex = {attrOut.bright, pixelBit ? attrOut.ink : attrOut.paper};

   assign rgb = ColourTable[colourIndex];

endmodule

// ==== cpuPorts.sv ====
`timescale 1ns/1ps

module cpuPorts
   import ulaCpuPkg::*;
(
   input  logic                    clk7,
   input  logic                    rst_n,
   input  cpuAddr_t                a,
   input  logic                    iorqN,
   input  logic                    rdN,
   input  logic                    wrN,
   input  cpuData_t                din,
   input  logic                    ear,
   input  logic [4:0]              kbd,
   input  logic                    issue2Keyboard,
   output cpuData_t                dout,
   output logic [FeBorderBits-1:0] border,
   output logic                    mic,
   output logic                    spk
);

   logic feSelect;
   logic feWrite;
   logic feRead;
   logic earProcessed;

   // Partial decode on A0 only
   assign feSelect = !iorqN && !a[FeSelectBit];
   assign feWrite  = feSelect && !wrN;
   assign feRead   = feSelect && !rdN;

   ////////////////////////////////////////////////////////////
   // Port 0xFE write
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         // Red border out of reset
         border <= FeBorderBits'(2);
         mic    <= 1'b0;
         spk    <= 1'b0;
      end else if (feWrite) begin
         border <= din[FeBorderLsb +: FeBorderBits];
         mic    <= din[FeMicBit];
         spk    <= din[FeSpkBit];
      end
   end

   ////////////////////////////////////////////////////////////
   // Port 0xFE read
   ////////////////////////////////////////////////////////////

   // Issue 2 boards also see MIC on the EAR input
   assign earProcessed = issue2Keyboard ? (ear ^ (spk | mic)) : (ear ^ spk);

   // Unused bits float high
   assign dout = feRead ? {1'b1, earProcessed, 1'b1, kbd} : 8'hFF;

endmodule

// ==== ulaTop.sv ====
`timescale 1ns/1ps

module ulaTop
   import ulaVideoPkg::*, ulaCpuPkg::*;
#(
   parameter int FlashBits = 5
) (
   input  logic       clk7,
   input  logic       rst_n,
   // CPU bus
   input  cpuAddr_t   a,
   input  logic       iorqN,
   input  logic       rdN,
   input  logic       wrN,
   input  cpuData_t   din,
   output cpuData_t   dout,
   // Video RAM
   output vramAddr_t  va,
   input  cpuData_t   vramData,
   // Tape and keyboard
   input  logic       ear,
   input  logic [4:0] kbd,
   input  logic       issue2Keyboard,
   output logic       mic,
   output logic       spk,
   // Video out
   output rgb9_t      rgb,
   output logic       hsync,
   output logic       vsync,
   output logic       intN
);

   hCount_t                  hc;
   vCount_t                  vc;
   logic                     flashPhase;
   logic [$bits(igrb_t)-2:0] borderColour;

   ulaFetchIf fetchBus ();

   rasterCounter #(
      .FlashBits (FlashBits)
   ) uRaster (
      .clk7       (clk7),
      .rst_n      (rst_n),
      .hc         (hc),
      .vc         (vc),
      .hsync      (hsync),
      .vsync      (vsync),
      .intN       (intN),
      .flashPhase (flashPhase)
   );

   fetchControl uFetch (
      .hc    (hc),
      .vc    (vc),
      .fetch (fetchBus.control)
   );

   videoDatapath uVideo (
      .clk7       (clk7),
      .hc         (hc),
      .vc         (vc),
      .vramData   (vramData),
      .border     (borderColour),
      .flashPhase (flashPhase),
      .fetch      (fetchBus.datapath),
      .va         (va),
      .rgb        (rgb)
   );

   cpuPorts uPorts (
      .clk7           (clk7),
      .rst_n          (rst_n),
      .a              (a),
      .iorqN          (iorqN),
      .rdN            (rdN),
      .wrN            (wrN),
      .din            (din),
      .ear            (ear),
      .kbd            (kbd),
      .issue2Keyboard (issue2Keyboard),
      .dout           (dout),
      .border         (borderColour),
      .mic            (mic),
      .spk            (spk)
   );

endmodule

// ==== tbClockGen.sv ====
`timescale 1ns/1ps

module tbClockGen #(
   parameter int PeriodNs    = 100,
   parameter int ResetCycles = 2
) (
   output logic clk7,
   output logic rst_n
);

   // Free running pixel clock
   initial begin
      clk7 = 1'b0;
      forever #(PeriodNs / 2) clk7 = ~clk7;
   end

   // Reset released just after a rising edge
   initial begin
      rst_n = 1'b0;
      repeat (ResetCycles) @(posedge clk7);
      #10 rst_n = 1'b1;
   end

endmodule

// ==== ulaTop_checker.sv ====
`timescale 1ns/1ps

module ulaTop_checker
   import ulaVideoPkg::*;
(
   input logic      clk7,
   input logic      rst_n,
   input logic      intN,
   input logic      hsync,
   input logic      vsync,
   input hCount_t   hc,
   input vCount_t   vc,
   input vramAddr_t va
);

   logic [9:0] intLowCount;
   logic       fetchSlot;

   // Cycles of the current interrupt pulse
   always_ff @(posedge clk7) begin
      if (!rst_n || intN) begin
         intLowCount <= '0;
      end else begin
         intLowCount <= intLowCount + 1'b1;
      end
   end

   // Second half of each 16 clock group inside the fetch area
   assign fetchSlot = (vc <= vCount_t'(PaperLastY)) && (hc <= hCount_t'(PaperLastX)) && hc[3];

   ////////////////////////////////////////////////////////////
   // Interrupt
   ////////////////////////////////////////////////////////////

   intPulseLength : assert property (@(posedge clk7) disable iff (!rst_n)
      $rose(intN) |-> intLowCount == 10'd64)
      else $error("interrupt pulse not 64 cycles long");

   intOnlyOnIntLine : assert property (@(posedge clk7) disable iff (!rst_n)
      !intN |-> vc == vCount_t'(IntLine))
      else $error("interrupt outside its line");

   ////////////////////////////////////////////////////////////
   // Address bus and syncs
   ////////////////////////////////////////////////////////////

   vaIdleZero : assert property (@(posedge clk7) disable iff (!rst_n)
      !fetchSlot |-> va == '0)
      else $error("video RAM address not zero outside fetch");

   hsyncWindow : assert property (@(posedge clk7) disable iff (!rst_n)
      !hsync |-> (hc >= hCount_t'(HsyncFirst) && hc <= hCount_t'(HsyncLast)))
      else $error("hsync low outside its window");

   vsyncWindow : assert property (@(posedge clk7) disable iff (!rst_n)
      !vsync |-> (vc >= vCount_t'(VsyncFirst) && vc <= vCount_t'(VsyncLast)))
      else $error("vsync low outside its window");

endmodule

bind ulaTop ulaTop_checker uChecker (
   .clk7  (clk7),
   .rst_n (rst_n),
   .intN  (intN),
   .hsync (hsync),
   .vsync (vsync),
   .hc    (hc),
   .vc    (vc),
   .va    (va)
);

// ==== tb_ulaTop.sv ====
`timescale 1ns/1ps

module tb_ulaTop
   import ulaVideoPkg::*, ulaCpuPkg::*;
;

   localparam int     PeriodNs    = 100;
   localparam longint FrameCycles = LineLength * FrameLines;
   // Pixel x shows while hc is x plus this
   localparam int     PixelDelay  = 13;
   // Level select codes held in the address field
   localparam int     SelInt      = 0;
   localparam int     SelHsync    = 1;
   localparam int     SelVsync    = 2;
   localparam int     SelMic      = 3;
   localparam int     SelSpk      = 4;

   typedef enum {OpWrite, OpRead, OpPixel, OpLevel} opKind_e;

   typedef struct {
      opKind_e    kind;
      cpuAddr_t   addr;
      cpuData_t   data;
      int         frame;
      int         line;
      int         pos;
      logic [8:0] expected;
   } step_t;

   logic       clk7;
   logic       rst_n;
   cpuAddr_t   a;
   logic       iorqN;
   logic       rdN;
   logic       wrN;
   cpuData_t   din;
   cpuData_t   dout;
   vramAddr_t  va;
   cpuData_t   vramData;
   logic       ear;
   logic [4:0] kbd;
   logic       issue2Keyboard;
   logic       mic;
   logic       spk;
   rgb9_t      rgb;
   logic       hsync;
   logic       vsync;
   logic       intN;

   logic [7:0] vram [16384];
   longint     cycles;
   step_t      steps [$];
   int         errorCount;
   logic       stepOk;

   // Port state as the table expects it
   logic [2:0] modelBorder;
   logic       modelMic;
   logic       modelSpk;

   tbClockGen #(.PeriodNs(PeriodNs), .ResetCycles(2)) uClock (.clk7(clk7), .rst_n(rst_n));

   ulaTop DUT (
      .clk7 (clk7), .rst_n (rst_n), .a (a), .iorqN (iorqN), .rdN (rdN), .wrN (wrN),
      .din (din), .dout (dout), .va (va), .vramData (vramData), .ear (ear), .kbd (kbd),
      .issue2Keyboard (issue2Keyboard), .mic (mic), .spk (spk), .rgb (rgb),
      .hsync (hsync), .vsync (vsync), .intN (intN)
   );

   // Video RAM answers without delay
   assign vramData = vram[va];

   // Counts clocks the way the raster does across lines and frames
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         cycles <= 0;
      end else begin
         cycles <= cycles + 1;
      end
   end

   ////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////

   function automatic rgb9_t refColour(int frame, int line, int x, logic [2:0] borderNow);
      vCount_t    v;
      logic [7:0] x8;
      vramAddr_t  bitAddr;
      vramAddr_t  atAddr;
      logic [7:0] pattern;
      attr_t      at;
      logic       phase;
      logic       inkOn;
      if (line > PaperLastY || x > PaperLastX) begin
         return ColourTable[{1'b0, borderNow}];
      end
      v       = vCount_t'(line);
      x8      = 8'(x);
      bitAddr = {1'b0, v[7:6], v[2:0], v[5:3], x8[7:3]};
      atAddr  = {1'b0, 3'b110, v[7:3], x8[7:3]};
      pattern = vram[bitAddr];
      at      = attr_t'(vram[atAddr]);
      // Flash counter equals the frame number modulo 32 on paper lines
      phase   = frame[4];
      inkOn   = pattern[7 - x8[2:0]] ^ (at.flash & phase);
      return ColourTable[{at.bright, inkOn ? at.ink : at.paper}];
   endfunction

   function automatic cpuData_t refRead(cpuAddr_t addr, logic [4:0] keys, logic earIn,
                                        logic issue2, logic micNow, logic spkNow);
      logic earOut;
      if (addr[0]) begin
         return 8'hFF;
      end
      earOut = issue2 ? (earIn ^ (spkNow | micNow)) : (earIn ^ spkNow);
      return {1'b1, earOut, 1'b1, keys};
   endfunction

   ////////////////////////////////////////////////////////////
   // Table building
   ////////////////////////////////////////////////////////////

   task automatic addWrite(int frame, int line, int pos, cpuData_t data);
      step_t s;
      s = '{OpWrite, 16'h00FE, data, frame, line, pos, 9'd0};
      steps.push_back(s);
      modelBorder = data[2:0];
      modelMic    = data[3];
      modelSpk    = data[4];
   endtask

   task automatic addRead(int frame, int line, int pos, cpuAddr_t addr, logic issue2);
      step_t      s;
      logic [4:0] keys;
      logic       earIn;
      keys  = 5'($urandom());
      earIn = 1'($urandom());
      s = '{OpRead, addr, {1'b0, issue2, earIn, keys}, frame, line, pos, 9'd0};
      s.expected = {1'b0, refRead(addr, keys, earIn, issue2, modelMic, modelSpk)};
      steps.push_back(s);
   endtask

   task automatic addPixel(int frame, int line, int x);
      step_t s;
      s = '{OpPixel, 16'h0000, 8'h00, frame, line, x, 9'd0};
      s.expected = refColour(frame, line, x, modelBorder);
      steps.push_back(s);
   endtask

   task automatic addLevel(int frame, int line, int pos, int sel, logic value);
      step_t s;
      s = '{OpLevel, cpuAddr_t'(sel), 8'h00, frame, line, pos, {8'd0, value}};
      steps.push_back(s);
   endtask

   task automatic addPaperChecks(int frame);
      int lines [8] = '{0, 7, 8, 63, 64, 100, 135, 191};
      int xs [12]   = '{0, 7, 8, 96, 97, 99, 100, 103, 104, 108, 131, 255};
      foreach (lines[i]) begin
         foreach (xs[j]) begin
            addPixel(frame, lines[i], xs[j]);
         end
      end
   endtask

   task automatic buildSteps();
      modelBorder = 3'd2;
      modelMic    = 1'b0;
      modelSpk    = 1'b0;
      addPaperChecks(0);
      // Border colours starting with the reset value
      addPixel(0, 250, 100);
      addWrite(0, 260, 10, 8'h0D);
      addLevel(0, 261, 10, SelMic, 1'b1);
      addLevel(0, 261, 20, SelSpk, 1'b0);
      addPixel(0, 262, 100);
      addRead(0, 264, 10, 16'h00FE, 1'b0);
      addRead(0, 264, 30, 16'h7FFE, 1'b1);
      addRead(0, 264, 50, 16'h00FF, 1'b1);
      addRead(0, 264, 70, 16'hFEFE, 1'b0);
      addWrite(0, 266, 10, 8'h16);
      addLevel(0, 267, 10, SelMic, 1'b0);
      addLevel(0, 267, 20, SelSpk, 1'b1);
      addPixel(0, 268, 100);
      addRead(0, 270, 10, 16'h00FE, 1'b0);
      addRead(0, 270, 30, 16'hBFFE, 1'b1);
      addRead(0, 270, 50, 16'h001F, 1'b0);
      addWrite(0, 272, 10, 8'h03);
      addPixel(0, 274, 100);
      addRead(0, 276, 10, 16'h00FE, 1'b1);
      // Sync and interrupt edges
      addLevel(1, 10, 343, SelHsync, 1'b1);
      addLevel(1, 10, 344, SelHsync, 1'b0);
      addLevel(1, 10, 375, SelHsync, 1'b0);
      addLevel(1, 10, 376, SelHsync, 1'b1);
      addLevel(1, 247, 0, SelVsync, 1'b1);
      addLevel(1, 247, 30, SelInt, 1'b1);
      addLevel(1, 248, 0, SelVsync, 1'b0);
      addLevel(1, 248, 1, SelInt, 1'b1);
      addLevel(1, 248, 2, SelInt, 1'b0);
      addLevel(1, 248, 65, SelInt, 1'b0);
      addLevel(1, 248, 66, SelInt, 1'b1);
      addLevel(1, 251, 447, SelVsync, 1'b0);
      addLevel(1, 252, 0, SelVsync, 1'b1);
      // Flash phase is set from frame 16 on
      addPaperChecks(16);
   endtask

   ////////////////////////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////////////////////////

   task automatic checkData(cpuData_t got, cpuData_t exp, string what);
      if (got !== exp) begin
         $display("Error at %0t: %s dout got %h expected %h", $time, what, got, exp);
         errorCount++;
         stepOk = 1'b0;
      end
   endtask

   task automatic checkColour(rgb9_t got, rgb9_t exp, string what);
      if (got !== exp) begin
         $display("Error at %0t: %s rgb got %h expected %h", $time, what, got, exp);
         errorCount++;
         stepOk = 1'b0;
      end
   endtask

   task automatic checkLevel(logic got, logic exp, string what);
      if (got !== exp) begin
         $display("Error at %0t: %s got %b expected %b", $time, what, got, exp);
         errorCount++;
         stepOk = 1'b0;
      end
   endtask

   function automatic logic sampleLevel(int sel);
      case (sel)
         SelInt:   return intN;
         SelHsync: return hsync;
         SelVsync: return vsync;
         SelMic:   return mic;
         default:  return spk;
      endcase
   endfunction

   // Lands 10 ns after the edge that starts the target cycle
   task automatic waitCycle(longint target);
      while (cycles < target) begin
         @(posedge clk7);
         #10;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////

   initial begin
      step_t  s;
      longint target;
      string  what;
      a              = 16'hFFFF;
      iorqN          = 1'b1;
      rdN            = 1'b1;
      wrN            = 1'b1;
      din            = 8'h00;
      ear            = 1'b0;
      kbd            = 5'h1F;
      issue2Keyboard = 1'b0;
      errorCount     = 0;
      void'($urandom(32'h4a7b_4caa));
      for (int i = 0; i < 16384; i++) begin
         vram[i] = 8'($urandom());
      end
      // One flashing and one steady cell on line 100
      vram[{1'b0, 2'b01, 3'b100, 3'b100, 5'd12}] = 8'hF0;
      vram[{1'b0, 2'b01, 3'b100, 3'b100, 5'd13}] = 8'h3C;
      vram[14'h198C] = 8'hC5;
      vram[14'h198D] = 8'h45;
      buildSteps();

      foreach (steps[i]) begin
         s      = steps[i];
         stepOk = 1'b1;
         target = longint'(s.frame) * FrameCycles + longint'(s.line) * LineLength + s.pos;
         if (s.kind == OpPixel) begin
            target += PixelDelay;
         end
         if (cycles > target) begin
            $display("Step %0d could not run, its raster position had already passed", i);
            errorCount++;
            stepOk = 1'b0;
         end
         waitCycle(target);
         $sformat(what, "frame %0d line %0d pos %0d", s.frame, s.line, s.pos);
         case (s.kind)
            OpWrite: begin
               a     = s.addr;
               din   = s.data;
               iorqN = 1'b0;
               wrN   = 1'b0;
               @(posedge clk7);
               #10;
               iorqN = 1'b1;
               wrN   = 1'b1;
               a     = 16'hFFFF;
            end
            OpRead: begin
               a              = s.addr;
               kbd            = s.data[4:0];
               ear            = s.data[5];
               issue2Keyboard = s.data[6];
               iorqN          = 1'b0;
               rdN            = 1'b0;
               #40;
               checkData(dout, cpuData_t'(s.expected), what);
               @(posedge clk7);
               #10;
               iorqN = 1'b1;
               rdN   = 1'b1;
               a     = 16'hFFFF;
            end
            OpPixel: begin
               #40;
               checkColour(rgb, rgb9_t'(s.expected), what);
            end
            default: begin
               #40;
               checkLevel(sampleLevel(int'(s.addr)), s.expected[0], what);
            end
         endcase
         $display("Step %0d %s %s %s", i, s.kind.name(), what, stepOk ? "ok" : "failed");
      end

      $display("Steps run: %0d, errors: %0d", steps.size(), errorCount);
      if (errorCount == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

   // 34 frames of pixel clocks plus 1 ms
   initial begin
      #(34.0 * LineLength * FrameLines * PeriodNs + 1.0e6);
      $display("Timeout: the test sequence did not finish in time");
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

// ==== sources.f ====
ulaVideoPkg.sv
ulaCpuPkg.sv
ulaFetchIf.sv
rasterCounter.sv
fetchControl.sv
videoDatapath.sv
cpuPorts.sv
ulaTop.sv
tbClockGen.sv
ulaTop_checker.sv
tb_ulaTop.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_ulaTop
RTL_TOP   ?= ulaTop
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	elif ! grep -q "NO ERRORS" $(LOG); then \
		echo "Simulation failed, no result line in $(LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
